// ==== common/divsqrt_config.svh ====
// ------------------------------------------------
// Build-time sizes of the divide/sqrt unit
// OP_W must be even so the root has OP_W/2 bits
// ------------------------------------------------
`ifndef DIVSQRT_CONFIG_SVH
`define DIVSQRT_CONFIG_SVH

// ------------------------------------------------
// Datapath widths
// ------------------------------------------------
`define DIVSQRT_OP_W 16 // Operand and result width
`define DIVSQRT_TAG_W 4 // Opaque transaction label

// ------------------------------------------------
// Elastic pipeline depths
// ------------------------------------------------
// Zero is legal for either, giving plain wires
`define DIVSQRT_INP_REGS 1 // Stages ahead of the FSM
`define DIVSQRT_OUT_REGS 1 // Stages after the FSM

`endif // DIVSQRT_CONFIG_SVH

// ==== common/divsqrt_pkg.sv ====
// ------------------------------------------------
// Shared types of the divide/sqrt unit
// ------------------------------------------------
`include "divsqrt_config.svh"

package divsqrt_pkg;

  // ------------------------------------------------
  // Payload types
  // ------------------------------------------------
  typedef logic [`DIVSQRT_OP_W-1:0]  operand_t; // Operands and results
  typedef logic [`DIVSQRT_TAG_W-1:0] tag_t;     // Returned unchanged with result

  // Bit 1 divide-by-zero, bit 0 inexact
  typedef logic [1:0] status_t;

  typedef enum logic {
    OP_DIV  = 1'b0, // Floor of a / b
    OP_SQRT = 1'b1  // Floor of sqrt(a), b unused
  } op_e;

  // ------------------------------------------------
  // FSM encodings
  // ------------------------------------------------
  typedef enum logic [1:0] {
    IDLE, // Waiting for work
    BUSY, // Engine running
    HOLD  // Result stalled by downstream
  } ctrl_state_e;

  typedef enum logic [1:0] {
    ENG_IDLE, // Nothing to do
    ENG_RUN,  // One result bit per cycle
    ENG_DONE  // Single-cycle done
  } eng_state_e;

endpackage

// ==== hw/divsqrt_pipe_regs.sv ====
// ------------------------------------------------
// Elastic valid/ready register chain, DEPTH >= 0
// Flush drops every stage; data regs have no reset
// ------------------------------------------------
`timescale 1ns/1ns

module divsqrt_pipe_regs #(
  parameter int unsigned DEPTH  = 1,
  parameter int unsigned DATA_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              flush_i,
  input  logic              valid_i,
  output logic              ready_o,
  input  logic [DATA_W-1:0] data_i,
  output logic              valid_o,
  input  logic              ready_i,
  output logic [DATA_W-1:0] data_o,
  output logic              any_valid_o  // Some stage holds an item
);

  // Index i is the view after i stages
  logic [DATA_W-1:0] stage_data  [0:DEPTH];
  logic              stage_valid [0:DEPTH];
  logic              stage_ready [0:DEPTH];
  logic              stage_occ   [0:DEPTH]; // Running OR of registered valids

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = valid_i;
  assign stage_occ[0]   = 1'b0; // Upstream valid is not ours yet
  assign ready_o        = stage_ready[0];

  for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
    logic              valid_q;
    logic [DATA_W-1:0] data_q;
    logic              load_en;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load_en        = stage_ready[i] & stage_valid[i]; // Real item moving in

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0; // Flush beats any transfer
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load_en) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
    assign stage_occ[i+1]   = stage_occ[i] | valid_q;
  end

  // Ready comes from downstream at the far end
  assign stage_ready[DEPTH] = ready_i;
  assign valid_o            = stage_valid[DEPTH];
  assign data_o             = stage_data[DEPTH];
  assign any_valid_o        = stage_occ[DEPTH];

  // A stalled item must not change under the consumer
  a_data_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i && !flush_i |=> $stable(data_o));

endmodule

// ==== hw/divsqrt_ctrl.sv ====
// ------------------------------------------------
// IDLE/BUSY/HOLD FSM between input pipe and engine
// One operation in flight; engine result is held
// ------------------------------------------------
`timescale 1ns/1ns

module divsqrt_ctrl (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  // Upstream side
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::operand_t opa_i,
  input  divsqrt_pkg::operand_t opb_i,
  input  divsqrt_pkg::tag_t     tag_i,
  // Engine side
  output logic                  eng_start_o,
  output divsqrt_pkg::op_e      eng_op_o,
  output divsqrt_pkg::operand_t eng_opa_o,
  output divsqrt_pkg::operand_t eng_opb_o,
  input  logic                  eng_busy_i,
  input  logic                  eng_done_i,
  input  divsqrt_pkg::operand_t eng_result_i,
  input  divsqrt_pkg::status_t  eng_status_i,
  // Downstream side
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output divsqrt_pkg::operand_t result_o,
  output divsqrt_pkg::status_t  status_o,
  output divsqrt_pkg::tag_t     tag_o,
  output logic                  busy_o
);

  divsqrt_pkg::ctrl_state_e state_q, state_d;
  divsqrt_pkg::tag_t        tag_q; // Label of the op in the engine
  logic                     slot_free; // Result slot empties this cycle
  logic                     res_valid; // Engine result offered downstream

  // ------------------------------------------------
  // Output offer and slot occupancy
  // ------------------------------------------------
  always_comb begin
    slot_free = 1'b0;
    res_valid = 1'b0;
    unique case (state_q)
      divsqrt_pkg::IDLE: slot_free = 1'b1;
      divsqrt_pkg::BUSY: begin
        res_valid = eng_done_i; // Offer in the done cycle itself
        slot_free = eng_done_i & out_ready_i;
      end
      divsqrt_pkg::HOLD: begin
        res_valid = 1'b1;
        slot_free = out_ready_i;
      end
      default: slot_free = 1'b0;
    endcase
  end

  // Engine busy low also covers its done cycle
  assign in_ready_o  = slot_free & ~eng_busy_i & ~flush_i;
  assign eng_start_o = in_valid_i & in_ready_o;
  assign out_valid_o = res_valid & ~flush_i; // Flush cancels the offer

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      divsqrt_pkg::IDLE: if (eng_start_o) state_d = divsqrt_pkg::BUSY;
      divsqrt_pkg::BUSY: begin
        if (eng_done_i) begin
          if (!out_ready_i)     state_d = divsqrt_pkg::HOLD; // Park the result
          else if (eng_start_o) state_d = divsqrt_pkg::BUSY; // Back to back
          else                  state_d = divsqrt_pkg::IDLE;
        end
      end
      divsqrt_pkg::HOLD: begin
        if (out_ready_i) begin
          state_d = eng_start_o ? divsqrt_pkg::BUSY : divsqrt_pkg::IDLE;
        end
      end
      default: state_d = divsqrt_pkg::IDLE;
    endcase
    if (flush_i) state_d = divsqrt_pkg::IDLE; // Flush overrides all
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= divsqrt_pkg::IDLE;
    else           state_q <= state_d;
  end

  // Tag rides beside the engine
  always_ff @(posedge clk_i) begin
    if (eng_start_o) tag_q <= tag_i;
  end

  // Engine latches these at start
  assign eng_op_o  = op_i;
  assign eng_opa_o = opa_i;
  assign eng_opb_o = opb_i;

  assign result_o = eng_result_i; // Engine keeps it stable until next start
  assign status_o = eng_status_i;
  assign tag_o    = tag_q;
  assign busy_o   = (state_q != divsqrt_pkg::IDLE);

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // A running engine always belongs to the op this FSM is tracking
  a_eng_tracked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    eng_busy_i |-> state_q == divsqrt_pkg::BUSY);

  a_out_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o || flush_i);

endmodule

// ==== iter_engine/iter_divsqrt.sv ====
// ------------------------------------------------
// Restoring divider and digit-by-digit sqrt, 1 bit/cycle
// Result and flags stay stable until the next start
// ------------------------------------------------
`timescale 1ns/1ns

`include "divsqrt_config.svh"

module iter_divsqrt (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  start_i,
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::operand_t opa_i,
  input  divsqrt_pkg::operand_t opb_i,
  output logic                  busy_o,
  output logic                  done_o,
  output divsqrt_pkg::operand_t result_o,
  output divsqrt_pkg::status_t  status_o
);

  localparam int unsigned W     = `DIVSQRT_OP_W;
  localparam int unsigned CNT_W = $clog2(W + 1);

  divsqrt_pkg::eng_state_e state_q;
  logic [CNT_W-1:0]        cnt_q;  // Iterations left
  divsqrt_pkg::op_e        op_q;
  divsqrt_pkg::operand_t   src_q;  // Dividend or radicand, MSB first
  divsqrt_pkg::operand_t   dvs_q;  // Divisor
  divsqrt_pkg::operand_t   res_q;  // Quotient or root, LSB shifted in
  logic [W:0]              rem_q;  // Partial remainder, one guard bit

  logic [W:0] rem_sh;  // Remainder with next source bits appended
  logic [W:0] subtr;   // Trial subtrahend
  logic [W:0] diff;
  logic       borrow;  // Trial went negative, restore
  logic       dz;

  // ------------------------------------------------
  // One iteration step
  // ------------------------------------------------
  always_comb begin
    if (op_q == divsqrt_pkg::OP_DIV) begin
      rem_sh = {rem_q[W-1:0], src_q[W-1]};
      subtr  = {1'b0, dvs_q};
    end else begin
      rem_sh = {rem_q[W-2:0], src_q[W-1:W-2]}; // Two radicand bits per root bit
      subtr  = {res_q[W-2:0], 2'b01};          // 4*root + 1
    end
  end

  assign {borrow, diff} = {1'b0, rem_sh} - {1'b0, subtr};

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= divsqrt_pkg::ENG_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= divsqrt_pkg::ENG_IDLE; // Abort, datapath left as is
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        divsqrt_pkg::ENG_RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) state_q <= divsqrt_pkg::ENG_DONE; // Last bit
        end
        default: begin // IDLE and DONE both take a new start
          state_q <= divsqrt_pkg::ENG_IDLE;
          if (start_i) begin
            state_q <= divsqrt_pkg::ENG_RUN;
            cnt_q   <= (op_i == divsqrt_pkg::OP_DIV) ? CNT_W'(W) : CNT_W'(W / 2);
          end
        end
      endcase
    end
  end

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (start_i && state_q != divsqrt_pkg::ENG_RUN) begin
      op_q  <= op_i;
      src_q <= opa_i;
      dvs_q <= opb_i;
      res_q <= '0;
      rem_q <= '0;
    end else if (state_q == divsqrt_pkg::ENG_RUN) begin
      rem_q <= borrow ? rem_sh : diff;    // Restore on borrow
      res_q <= {res_q[W-2:0], ~borrow};
      src_q <= (op_q == divsqrt_pkg::OP_DIV) ? {src_q[W-2:0], 1'b0}
                                             : {src_q[W-3:0], 2'b00};
    end
  end

  // Zero divisor naturally yields all ones; remainder meaningless then
  assign dz = (op_q == divsqrt_pkg::OP_DIV) && (dvs_q == '0);

  assign status_o = {dz, ~dz & (rem_q != '0)};
  assign result_o = res_q;
  assign busy_o   = (state_q == divsqrt_pkg::ENG_RUN);
  assign done_o   = (state_q == divsqrt_pkg::ENG_DONE);

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_o |=> !done_o);

endmodule

// ==== hw/divsqrt_top.sv ====
// ------------------------------------------------
// Multicycle unsigned divide/sqrt with tag and flush
// Variable latency; results leave in acceptance order
// ------------------------------------------------
`timescale 1ns/1ns

`include "divsqrt_config.svh"

module divsqrt_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::operand_t opa_i,
  input  divsqrt_pkg::operand_t opb_i,
  input  divsqrt_pkg::tag_t     tag_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output divsqrt_pkg::operand_t result_o,
  output divsqrt_pkg::status_t  status_o,
  output divsqrt_pkg::tag_t     tag_o,
  output logic                  busy_o
);

  // Payload widths of the two pipes
  localparam int unsigned IN_W  = $bits(divsqrt_pkg::op_e) + 2 * $bits(divsqrt_pkg::operand_t)
                                  + $bits(divsqrt_pkg::tag_t);
  localparam int unsigned OUT_W = $bits(divsqrt_pkg::operand_t) + $bits(divsqrt_pkg::status_t)
                                  + $bits(divsqrt_pkg::tag_t);

  logic [IN_W-1:0]  inp_data;  // {op, a, b, tag} after input pipe
  logic [OUT_W-1:0] out_data;  // {result, status, tag} into output pipe
  logic             inp_valid, inp_ready, inp_busy;
  logic             res_valid, res_ready, out_busy, ctrl_busy;

  divsqrt_pkg::operand_t res, eng_opa, eng_opb, eng_res;
  divsqrt_pkg::status_t  res_status, eng_status;
  divsqrt_pkg::tag_t     res_tag;
  divsqrt_pkg::op_e      eng_op;
  logic                  eng_start, eng_busy, eng_done;

  // ------------------------------------------------
  // Input pipeline
  // ------------------------------------------------
  divsqrt_pipe_regs #(.DEPTH(`DIVSQRT_INP_REGS), .DATA_W(IN_W)) u_inp_pipe (
    .clk_i, .arst_n_i, .flush_i,
    .valid_i(in_valid_i), .ready_o(in_ready_o), .data_i({op_i, opa_i, opb_i, tag_i}),
    .valid_o(inp_valid), .ready_i(inp_ready), .data_o(inp_data),
    .any_valid_o(inp_busy)
  );

  // ------------------------------------------------
  // Control and engine
  // ------------------------------------------------
  divsqrt_ctrl u_ctrl (
    .clk_i, .arst_n_i, .flush_i,
    .in_valid_i(inp_valid), .in_ready_o(inp_ready),
    .op_i(divsqrt_pkg::op_e'(inp_data[IN_W-1])),  // Unpack payload
    .opa_i(inp_data[IN_W-2 -: `DIVSQRT_OP_W]),
    .opb_i(inp_data[`DIVSQRT_TAG_W +: `DIVSQRT_OP_W]),
    .tag_i(inp_data[`DIVSQRT_TAG_W-1:0]),
    .eng_start_o(eng_start), .eng_op_o(eng_op), .eng_opa_o(eng_opa), .eng_opb_o(eng_opb),
    .eng_busy_i(eng_busy), .eng_done_i(eng_done),
    .eng_result_i(eng_res), .eng_status_i(eng_status),
    .out_valid_o(res_valid), .out_ready_i(res_ready),
    .result_o(res), .status_o(res_status), .tag_o(res_tag), .busy_o(ctrl_busy)
  );

  iter_divsqrt u_engine (
    .clk_i, .arst_n_i, .flush_i,
    .start_i(eng_start), .op_i(eng_op), .opa_i(eng_opa), .opb_i(eng_opb),
    .busy_o(eng_busy), .done_o(eng_done), .result_o(eng_res), .status_o(eng_status)
  );

  // ------------------------------------------------
  // Output pipeline
  // ------------------------------------------------
  divsqrt_pipe_regs #(.DEPTH(`DIVSQRT_OUT_REGS), .DATA_W(OUT_W)) u_out_pipe (
    .clk_i, .arst_n_i, .flush_i,
    .valid_i(res_valid), .ready_o(res_ready), .data_i({res, res_status, res_tag}),
    .valid_o(out_valid_o), .ready_i(out_ready_i), .data_o(out_data),
    .any_valid_o(out_busy)
  );

  assign {result_o, status_o, tag_o} = out_data;
  assign busy_o = inp_busy | ctrl_busy | out_busy; // Anything held anywhere

endmodule

// ==== test/tb_divsqrt.sv ====
// ------------------------------------------------
// Random divide/sqrt traffic against a reference model
// Inputs change 1 ns after posedge, outputs read at negedge
// ------------------------------------------------
`timescale 1ns/1ns

`include "divsqrt_config.svh"

module tb_divsqrt;

  localparam int K_DIV  = 0; // Divides with nonzero divisor
  localparam int K_SQRT = 1; // Square roots
  localparam int K_DZ   = 2; // Divides by zero
  localparam int K_MIX  = 3; // All of the above

  logic                  clk_i, arst_n_i, flush_i;
  logic                  in_valid_i, in_ready_o, out_valid_o, out_ready_i, busy_o;
  divsqrt_pkg::op_e      op_i;
  divsqrt_pkg::operand_t opa_i, opb_i, result_o;
  divsqrt_pkg::tag_t     tag_i, tag_o;
  divsqrt_pkg::status_t  status_o;

  integer seed = 32'heef;
  bit     accepted;  // Input handshake seen in the last cycle
  divsqrt_pkg::tag_t     next_tag;
  divsqrt_pkg::operand_t exp_res_q[$]; // Expected results in acceptance order
  divsqrt_pkg::status_t  exp_st_q[$];
  divsqrt_pkg::tag_t     exp_tag_q[$];

  divsqrt_top dut0 (.*);

  always #4 clk_i = ~clk_i; // 8 ns period

  // ------------------------------------------------
  // Error handling and compares
  // ------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_operand(input string name, input divsqrt_pkg::operand_t got,
                               input divsqrt_pkg::operand_t exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_status(input string name, input divsqrt_pkg::status_t got,
                              input divsqrt_pkg::status_t exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_tag(input string name, input divsqrt_pkg::tag_t got,
                           input divsqrt_pkg::tag_t exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp));
  endtask

  // ------------------------------------------------
  // Reference model, straight from the arithmetic rules
  // ------------------------------------------------
  task automatic push_expected();
    divsqrt_pkg::operand_t res;
    divsqrt_pkg::status_t  st;
    int                    root;
    if (op_i == divsqrt_pkg::OP_DIV) begin
      if (opb_i == '0) begin
        res = '1;      // All ones on zero divisor
        st  = 2'b10;
      end else begin
        res = opa_i / opb_i;
        st  = {1'b0, (opa_i % opb_i) != '0}; // Inexact when remainder left
      end
    end else begin
      root = 0;
      while ((root + 1) * (root + 1) <= int'(opa_i)) root++; // Largest root not above a
      res = divsqrt_pkg::operand_t'(root);
      st  = {1'b0, (root * root) != int'(opa_i)};
    end
    exp_res_q.push_back(res);
    exp_st_q.push_back(st);
    exp_tag_q.push_back(tag_i);
  endtask

  // One clock: log handshakes before the edge, then step past it
  task automatic tick();
    accepted = 1'b0;
    @(negedge clk_i);
    if (out_valid_o && exp_res_q.size() == 0)
      abort_run("A result came out with no operation outstanding");
    if (out_valid_o && out_ready_i && !flush_i) begin
      check_operand("result_o", result_o, exp_res_q.pop_front());
      check_status("status_o", status_o, exp_st_q.pop_front());
      check_tag("tag_o", tag_o, exp_tag_q.pop_front());
    end
    if (in_valid_i && in_ready_o && !flush_i) begin
      push_expected();
      accepted = 1'b1;
    end
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  task automatic next_stimulus(input int kind);
    int pick;
    int r;
    pick = kind;
    if (kind == K_MIX) begin
      r    = $random(seed) & 7;
      pick = (r < 4) ? K_DIV : (r < 7) ? K_SQRT : K_DZ; // Zero divisor now and then
    end
    opa_i    = $random(seed);
    opb_i    = $random(seed);
    tag_i    = next_tag;
    next_tag = next_tag + 1'b1;
    if (pick == K_SQRT) begin
      op_i = divsqrt_pkg::OP_SQRT;
      if ($random(seed) & 1) begin
        r     = $random(seed) & ((1 << (`DIVSQRT_OP_W / 2)) - 1);
        opa_i = divsqrt_pkg::operand_t'(r * r); // Exact squares too
      end
    end else begin
      op_i  = divsqrt_pkg::OP_DIV;
      opb_i = opb_i >> ({$random(seed)} % `DIVSQRT_OP_W); // Spread divisor sizes
      if (pick == K_DZ) opb_i = '0;
      else if (opb_i == '0) opb_i = 1;
    end
  endtask

  // Issue count ops with random gaps and drain all results
  task automatic run_ops(input int count, input int kind, input bit backpressure);
    int issued;
    int guard;
    issued = 0;
    guard  = 0;
    while (issued < count || in_valid_i || exp_res_q.size() != 0) begin
      if (!in_valid_i && issued < count && ($random(seed) & 3) != 0) begin
        next_stimulus(kind);
        in_valid_i = 1'b1;
        issued++;
      end
      out_ready_i = backpressure ? ($random(seed) & 1) : 1'b1;
      tick();
      if (accepted) in_valid_i = 1'b0;
      guard++;
      if (guard > count * 60 + 200)
        abort_run("Timed out waiting for all results to come back");
    end
    out_ready_i = 1'b1;
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin : main_seq
    int loaded;
    int guard;
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    op_i        = divsqrt_pkg::OP_DIV;
    opa_i       = '0;
    opb_i       = '0;
    tag_i       = '0;
    next_tag    = '0;
    repeat (8) @(posedge clk_i);
    #1 arst_n_i = 1'b1;

    // Idle after reset
    @(negedge clk_i);
    check_level("out_valid_o", out_valid_o, 1'b0);
    check_level("busy_o", busy_o, 1'b0);
    check_level("in_ready_o", in_ready_o, 1'b1);
    @(posedge clk_i);
    #1;

    run_ops(40, K_DIV, 1'b0);
    run_ops(30, K_SQRT, 1'b0);
    run_ops(8, K_DZ, 1'b0);
    run_ops(80, K_MIX, 1'b1); // Output stalled about half the time

    // ------------------------------------------------
    // Flush with work in every stage
    // ------------------------------------------------
    out_ready_i = 1'b0;
    loaded      = 0;
    guard       = 0;
    while (loaded < 3) begin
      if (!in_valid_i) begin
        next_stimulus(K_MIX);
        in_valid_i = 1'b1;
      end
      tick();
      if (accepted) begin
        in_valid_i = 1'b0;
        loaded++;
      end
      guard++;
      if (guard > 200) abort_run("Timed out loading operations ahead of the flush");
    end
    check_level("busy_o", busy_o, 1'b1);
    flush_i = 1'b1;
    tick();
    flush_i = 1'b0;
    exp_res_q.delete(); // Flushed work never returns
    exp_st_q.delete();
    exp_tag_q.delete();
    @(negedge clk_i);
    check_level("busy_o", busy_o, 1'b0);
    check_level("out_valid_o", out_valid_o, 1'b0);
    @(posedge clk_i);
    #1;
    out_ready_i = 1'b1;
    repeat (40) tick(); // Watch for stale results
    run_ops(6, K_MIX, 1'b0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+common
common/divsqrt_pkg.sv
hw/divsqrt_pipe_regs.sv
hw/divsqrt_ctrl.sv
iter_engine/iter_divsqrt.sv
hw/divsqrt_top.sv
test/tb_divsqrt.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divide/sqrt testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_divsqrt -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_divsqrt" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation run exited with status $run_status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
fi
echo "RESULT: FAIL"
exit 1
